// File: ctrl_cfg.svh
`ifndef CTRL_CFG_SVH
`define CTRL_CFG_SVH

// APB byte offsets 0h..Ch
`define CTRL_APB_AW 4

// joystick ports merged by the mapper
`define CTRL_NUM_JOY 2

`endif

// File: input_pkg.sv
package input_pkg;

	// keyboard button slots in the key state word
	typedef enum logic [3:0] {
		k_up,
		k_down,
		k_left,
		k_right,
		k_coin,
		k_start1,
		k_start2,
		k_fire1,
		k_fire2,
		k_fire3
	} key_idx_t;

	localparam int NUM_KEYS = 10;

	localparam logic [7:0] SC_UP    = 8'h75;
	localparam logic [7:0] SC_DOWN  = 8'h72;
	localparam logic [7:0] SC_LEFT  = 8'h6B;
	localparam logic [7:0] SC_RIGHT = 8'h74;
	localparam logic [7:0] SC_ESC   = 8'h76; // coin
	localparam logic [7:0] SC_F1    = 8'h05; // start 1
	localparam logic [7:0] SC_F2    = 8'h06; // start 2
	localparam logic [7:0] SC_CTRL  = 8'h14; // fire 3
	localparam logic [7:0] SC_ALT   = 8'h11; // fire 2, bomb
	localparam logic [7:0] SC_SPACE = 8'h29; // fire 1

	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE  = 4;
	localparam int JOY_BOMB  = 5;

	localparam int CT_UP     = 0;
	localparam int CT_DOWN   = 1;
	localparam int CT_LEFT   = 2;
	localparam int CT_RIGHT  = 3;
	localparam int CT_FIRE   = 4;
	localparam int CT_BOMB   = 5;
	localparam int CT_START1 = 6;
	localparam int CT_START2 = 7;
	localparam int CT_COIN   = 8;
	localparam int CT_WIDTH  = 9;

endpackage

// File: regmap_pkg.sv
package regmap_pkg;

	// byte offsets on the APB port
	localparam logic [3:0] REG_CONFIG   = 4'h0; // rw
	localparam logic [3:0] REG_CONTROLS = 4'h4; // ro, mapped controls
	localparam logic [3:0] REG_KEYS     = 4'h8; // ro, held keys
	localparam logic [3:0] REG_ID       = 4'hC; // ro

	// REG_CONFIG fields
	localparam int CFG_ROTATE   = 0;
	localparam int CFG_SCAN_LSB = 1;
	localparam int CFG_SCAN_MSB = 2;
	localparam int CFG_GAME_RST = 3;
	localparam int CFG_BITS     = 4;

	localparam logic [31:0] CORE_ID = 32'h4241_4731;

endpackage

// File: ps2_key_decoder.sv
`timescale 1ns/1ps

module ps2_key_decoder (
	input  logic                            clock_24,
	input  logic                            rst_n,
	input  logic [10:0]                     ps2_key,
	output logic [input_pkg::NUM_KEYS-1:0] keys
);

	logic                toggle_q;
	logic                new_event;
	logic                pressed;
	logic [7:0]          code;
	logic                hit;
	input_pkg::key_idx_t idx;

	assign new_event = ps2_key[10] != toggle_q;
	assign pressed   = ps2_key[9];
	assign code      = ps2_key[7:0];

	// scan code to key slot
	always_comb begin
		hit = 1'b1;
		idx = input_pkg::k_up;
		case (code)
			input_pkg::SC_UP:    idx = input_pkg::k_up;
			input_pkg::SC_DOWN:  idx = input_pkg::k_down;
			input_pkg::SC_LEFT:  idx = input_pkg::k_left;
			input_pkg::SC_RIGHT: idx = input_pkg::k_right;
			input_pkg::SC_ESC:   idx = input_pkg::k_coin;
			input_pkg::SC_F1:    idx = input_pkg::k_start1;
			input_pkg::SC_F2:    idx = input_pkg::k_start2;
			input_pkg::SC_SPACE: idx = input_pkg::k_fire1;
			input_pkg::SC_ALT:   idx = input_pkg::k_fire2;
			input_pkg::SC_CTRL:  idx = input_pkg::k_fire3;
			default:             hit = 1'b0; // not a game key
		endcase
	end

	always_ff @(posedge clock_24) begin
		if (!rst_n) begin
			toggle_q <= 1'b0;
			keys     <= '0;
		end else begin
			toggle_q <= ps2_key[10];
			if (new_event && hit) begin
				keys[idx] <= pressed; // release clears
			end
		end
	end

endmodule

// File: ctrl_apb_regs.sv
`timescale 1ns/1ps
`include "ctrl_cfg.svh"

module ctrl_apb_regs (
	input  logic                            clock_24,
	input  logic                            rst_n,
	input  logic [`CTRL_APB_AW-1:0]         paddr,
	input  logic                            psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  logic [31:0]                     pwdata,
	input  logic [input_pkg::CT_WIDTH-1:0] controls,
	input  logic [input_pkg::NUM_KEYS-1:0] keys,
	output logic [31:0]                     prdata,
	output logic                            pready,
	output logic                            pslverr,
	output logic                            rotate,
	output logic [1:0]                      scanlines,
	output logic                            game_reset
);

	logic                            setup;
	logic                            access;
	logic                            addr_ok;
	logic                            read_only;
	logic                            bad;
	logic                            wr_cfg;
	logic [31:0]                     rd_mux;
	logic [regmap_pkg::CFG_BITS-1:0] cfg_q;

	assign setup  = psel && !penable;
	assign access = psel && penable;
	assign pready = access; // no wait states

	always_comb begin
		addr_ok   = 1'b1;
		read_only = 1'b1;
		rd_mux    = '0;
		case (paddr)
			regmap_pkg::REG_CONFIG: begin
				read_only = 1'b0;
				rd_mux    = 32'(cfg_q);
			end
			regmap_pkg::REG_CONTROLS: rd_mux = 32'(controls);
			regmap_pkg::REG_KEYS:     rd_mux = 32'(keys);
			regmap_pkg::REG_ID:       rd_mux = regmap_pkg::CORE_ID;
			default:                  addr_ok = 1'b0;
		endcase
	end

	assign bad    = !addr_ok || (pwrite && read_only);
	assign wr_cfg = access && pwrite && (paddr == regmap_pkg::REG_CONFIG);

	always_ff @(posedge clock_24) begin
		if (!rst_n) begin
			cfg_q <= '0;
		end else if (wr_cfg) begin
			cfg_q <= pwdata[regmap_pkg::CFG_BITS-1:0];
		end
	end

	// response is built in setup so it is there for the access phase
	always_ff @(posedge clock_24) begin
		if (!rst_n) begin
			prdata  <= '0;
			pslverr <= 1'b0;
		end else if (setup) begin
			pslverr <= bad;
			prdata  <= (pwrite || !addr_ok) ? 32'd0 : rd_mux;
		end else begin
			pslverr <= 1'b0;
			prdata  <= '0;
		end
	end

	assign rotate     = cfg_q[regmap_pkg::CFG_ROTATE];
	assign scanlines  = cfg_q[regmap_pkg::CFG_SCAN_MSB:regmap_pkg::CFG_SCAN_LSB];
	assign game_reset = cfg_q[regmap_pkg::CFG_GAME_RST];

endmodule

// File: control_mapper.sv
`timescale 1ns/1ps
`include "ctrl_cfg.svh"

module control_mapper (
	input  logic                            clock_24,
	input  logic                            rst_n,
	input  logic [input_pkg::NUM_KEYS-1:0] keys,
	input  logic [7:0]                      joystick_0,
	input  logic [7:0]                      joystick_1,
	input  logic                            rotate,
	output logic [input_pkg::CT_WIDTH-1:0] controls
);

	logic [7:0]                      joy [`CTRL_NUM_JOY];
	logic [7:0]                      joy_any;
	logic                            m_up;
	logic                            m_down;
	logic                            m_left;
	logic                            m_right;
	logic [input_pkg::CT_WIDTH-1:0] ctl_nxt;

	assign joy[0] = joystick_0;
	assign joy[1] = joystick_1;

	always_comb begin
		joy_any = '0;
		for (int i = 0; i < `CTRL_NUM_JOY; i++) begin
			joy_any = joy_any | joy[i];
		end
	end

	assign m_up    = keys[input_pkg::k_up]    | joy_any[input_pkg::JOY_UP];
	assign m_down  = keys[input_pkg::k_down]  | joy_any[input_pkg::JOY_DOWN];
	assign m_left  = keys[input_pkg::k_left]  | joy_any[input_pkg::JOY_LEFT];
	assign m_right = keys[input_pkg::k_right] | joy_any[input_pkg::JOY_RIGHT];

	always_comb begin
		ctl_nxt = '0;
		if (rotate) begin // cabinet turned a quarter
			ctl_nxt[input_pkg::CT_UP]    = m_left;
			ctl_nxt[input_pkg::CT_DOWN]  = m_right;
			ctl_nxt[input_pkg::CT_LEFT]  = m_down;
			ctl_nxt[input_pkg::CT_RIGHT] = m_up;
		end else begin
			ctl_nxt[input_pkg::CT_UP]    = m_up;
			ctl_nxt[input_pkg::CT_DOWN]  = m_down;
			ctl_nxt[input_pkg::CT_LEFT]  = m_left;
			ctl_nxt[input_pkg::CT_RIGHT] = m_right;
		end
		ctl_nxt[input_pkg::CT_FIRE]   = keys[input_pkg::k_fire1] | joy_any[input_pkg::JOY_FIRE];
		ctl_nxt[input_pkg::CT_BOMB]   = keys[input_pkg::k_fire2] | joy_any[input_pkg::JOY_BOMB];
		ctl_nxt[input_pkg::CT_START1] = keys[input_pkg::k_start1];
		ctl_nxt[input_pkg::CT_START2] = keys[input_pkg::k_start2];
		ctl_nxt[input_pkg::CT_COIN]   = keys[input_pkg::k_coin];
	end

	always_ff @(posedge clock_24) begin
		if (!rst_n) begin
			controls <= '0;
		end else begin
			controls <= ctl_nxt;
		end
	end

endmodule

// File: arcade_input_top.sv
`timescale 1ns/1ps
`include "ctrl_cfg.svh"

module arcade_input_top (
	input  logic                            clock_24,
	input  logic                            rst_n,
	input  logic [10:0]                     ps2_key,
	input  logic [7:0]                      joystick_0,
	input  logic [7:0]                      joystick_1,
	input  logic [`CTRL_APB_AW-1:0]         paddr,
	input  logic                            psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  logic [31:0]                     pwdata,
	output logic [31:0]                     prdata,
	output logic                            pready,
	output logic                            pslverr,
	output logic [input_pkg::CT_WIDTH-1:0] controls,
	output logic [1:0]                      scanlines,
	output logic                            game_reset
);

	logic [input_pkg::NUM_KEYS-1:0] keys; // held keyboard buttons
	logic                            rotate;

	ps2_key_decoder ps2_key_decoder_inst (
		.clock_24 (clock_24),
		.rst_n    (rst_n),
		.ps2_key  (ps2_key),
		.keys     (keys)
	);

	ctrl_apb_regs ctrl_apb_regs_inst (
		.clock_24   (clock_24),
		.rst_n      (rst_n),
		.paddr      (paddr),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.pwdata     (pwdata),
		.controls   (controls),
		.keys       (keys),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.rotate     (rotate),
		.scanlines  (scanlines),
		.game_reset (game_reset)
	);

	control_mapper control_mapper_inst (
		.clock_24   (clock_24),
		.rst_n      (rst_n),
		.keys       (keys),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.rotate     (rotate),
		.controls   (controls)
	);

endmodule

// File: arcade_input_chk.sv
`timescale 1ns/1ps

module arcade_input_chk (
	input logic                            clock_24,
	input logic                            rst_n,
	input logic                            psel,
	input logic                            penable,
	input logic                            pready,
	input logic                            pslverr,
	input logic                            game_reset,
	input logic [input_pkg::CT_WIDTH-1:0] controls
);

	pready_in_access: assert property (@(posedge clock_24) disable iff (!rst_n)
		(psel && penable) |-> pready)
		else $error("pready low during an APB access phase");

	// error response only while the access phase is open
	pslverr_in_access: assert property (@(posedge clock_24) disable iff (!rst_n)
		pslverr |-> (psel && penable))
		else $error("pslverr high outside an APB access phase");

	game_reset_after_reset: assert property (@(posedge clock_24)
		!rst_n |=> (game_reset == 1'b0))
		else $error("game_reset not cleared by reset");

	controls_after_reset: assert property (@(posedge clock_24)
		!rst_n |=> (controls == '0))
		else $error("controls not cleared by reset");

endmodule

bind ctrl_apb_regs arcade_input_chk arcade_input_chk_inst (
	.clock_24   (clock_24),
	.rst_n      (rst_n),
	.psel       (psel),
	.penable    (penable),
	.pready     (pready),
	.pslverr    (pslverr),
	.game_reset (game_reset),
	.controls   (controls)
);

// File: tb_arcade_input.sv
`timescale 1ns/1ps
`include "ctrl_cfg.svh"

module tb_arcade_input;

	localparam int         TIMEOUT    = 20;
	localparam int         NUM_RANDOM = 40;
	localparam logic [1:0] OP_NONE    = 2'd0;
	localparam logic [1:0] OP_WR      = 2'd1;
	localparam logic [1:0] OP_RD      = 2'd2;

	// ten game keys first, then two codes the decoder ignores
	localparam logic [7:0] CODE_POOL [12] = '{
		input_pkg::SC_UP, input_pkg::SC_DOWN, input_pkg::SC_LEFT, input_pkg::SC_RIGHT,
		input_pkg::SC_ESC, input_pkg::SC_F1, input_pkg::SC_F2, input_pkg::SC_SPACE,
		input_pkg::SC_ALT, input_pkg::SC_CTRL, 8'h1C, 8'h5A
	};

	typedef struct packed {
		logic [10:0]                     key;
		logic [7:0]                      j0;
		logic [7:0]                      j1;
		logic [1:0]                      op;
		logic [`CTRL_APB_AW-1:0]         addr;
		logic [31:0]                     wdata;
		logic [31:0]                     exp_data;
		logic                            exp_err;
		logic [input_pkg::CT_WIDTH-1:0] exp_ctrl;
		logic [1:0]                      exp_scan;
		logic                            exp_rst;
		logic [1:0]                      lat; // falling edges to wait before the check
	} row_t;

	logic                            clock_24;
	logic                            rst_n;
	logic [10:0]                     ps2_key;
	logic [7:0]                      joystick_0;
	logic [7:0]                      joystick_1;
	logic [`CTRL_APB_AW-1:0]         paddr;
	logic                            psel;
	logic                            penable;
	logic                            pwrite;
	logic [31:0]                     pwdata;
	logic [31:0]                     prdata;
	logic                            pready;
	logic                            pslverr;
	logic [input_pkg::CT_WIDTH-1:0] controls;
	logic [1:0]                      scanlines;
	logic                            game_reset;

	row_t                            rows [$];
	int                              value_errs;
	int                              timeout_errs;
	logic [31:0]                     rng;
	logic                            m_toggle; // reference state of the player inputs
	logic [input_pkg::NUM_KEYS-1:0] m_keys;
	logic [regmap_pkg::CFG_BITS-1:0] m_cfg;
	logic [10:0]                     m_ps2;
	logic [7:0]                      m_j0;
	logic [7:0]                      m_j1;

	arcade_input_top arcade_input_top_inst (
		.clock_24   (clock_24),
		.rst_n      (rst_n),
		.ps2_key    (ps2_key),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.paddr      (paddr),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.controls   (controls),
		.scanlines  (scanlines),
		.game_reset (game_reset)
	);

	initial begin
		clock_24 = 1'b0;
		forever #5 clock_24 = ~clock_24;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int key_slot(input logic [7:0] code);
		case (code)
			input_pkg::SC_UP:    return int'(input_pkg::k_up);
			input_pkg::SC_DOWN:  return int'(input_pkg::k_down);
			input_pkg::SC_LEFT:  return int'(input_pkg::k_left);
			input_pkg::SC_RIGHT: return int'(input_pkg::k_right);
			input_pkg::SC_ESC:   return int'(input_pkg::k_coin);
			input_pkg::SC_F1:    return int'(input_pkg::k_start1);
			input_pkg::SC_F2:    return int'(input_pkg::k_start2);
			input_pkg::SC_SPACE: return int'(input_pkg::k_fire1);
			input_pkg::SC_ALT:   return int'(input_pkg::k_fire2);
			input_pkg::SC_CTRL:  return int'(input_pkg::k_fire3);
			default:             return -1;
		endcase
	endfunction

	function automatic logic [input_pkg::CT_WIDTH-1:0] expected_controls(
		input logic [input_pkg::NUM_KEYS-1:0] k, input logic [7:0] a, input logic [7:0] b,
		input logic rot);
		logic [7:0]                      j;
		logic                            up;
		logic                            dn;
		logic                            lf;
		logic                            rt;
		logic [input_pkg::CT_WIDTH-1:0] c;
		j  = a | b;
		up = k[input_pkg::k_up] | j[input_pkg::JOY_UP];
		dn = k[input_pkg::k_down] | j[input_pkg::JOY_DOWN];
		lf = k[input_pkg::k_left] | j[input_pkg::JOY_LEFT];
		rt = k[input_pkg::k_right] | j[input_pkg::JOY_RIGHT];
		c  = '0;
		c[input_pkg::CT_UP]     = rot ? lf : up;
		c[input_pkg::CT_DOWN]   = rot ? rt : dn;
		c[input_pkg::CT_LEFT]   = rot ? dn : lf;
		c[input_pkg::CT_RIGHT]  = rot ? up : rt;
		c[input_pkg::CT_FIRE]   = k[input_pkg::k_fire1] | j[input_pkg::JOY_FIRE];
		c[input_pkg::CT_BOMB]   = k[input_pkg::k_fire2] | j[input_pkg::JOY_BOMB];
		c[input_pkg::CT_START1] = k[input_pkg::k_start1];
		c[input_pkg::CT_START2] = k[input_pkg::k_start2];
		c[input_pkg::CT_COIN]   = k[input_pkg::k_coin];
		return c;
	endfunction

	task automatic push_row(input logic [1:0] op, input logic [`CTRL_APB_AW-1:0] addr,
		input logic [31:0] wdata, input logic [31:0] exp_data, input logic exp_err,
		input logic [1:0] lat);
		row_t r;
		r.key      = m_ps2;
		r.j0       = m_j0;
		r.j1       = m_j1;
		r.op       = op;
		r.addr     = addr;
		r.wdata    = wdata;
		r.exp_data = exp_data;
		r.exp_err  = exp_err;
		r.exp_ctrl = expected_controls(m_keys, m_j0, m_j1, m_cfg[regmap_pkg::CFG_ROTATE]);
		r.exp_scan = m_cfg[regmap_pkg::CFG_SCAN_MSB:regmap_pkg::CFG_SCAN_LSB];
		r.exp_rst  = m_cfg[regmap_pkg::CFG_GAME_RST];
		r.lat      = lat;
		rows.push_back(r);
	endtask

	task automatic add_key(input logic [7:0] code, input logic pressed);
		logic [input_pkg::NUM_KEYS-1:0] mask;
		int                              slot;
		slot     = key_slot(code);
		m_toggle = ~m_toggle;
		m_ps2    = {m_toggle, pressed, 1'b0, code};
		if (slot >= 0) begin
			mask   = {{(input_pkg::NUM_KEYS-1){1'b0}}, 1'b1} << slot;
			m_keys = pressed ? (m_keys | mask) : (m_keys & ~mask);
		end
		push_row(OP_NONE, '0, '0, '0, 1'b0, 2'd2);
	endtask

	task automatic add_repeat(input logic [7:0] code, input logic pressed);
		m_ps2 = {m_toggle, pressed, 1'b0, code}; // toggle unchanged, so no event
		push_row(OP_NONE, '0, '0, '0, 1'b0, 2'd2);
	endtask

	task automatic add_joy(input logic [7:0] a, input logic [7:0] b);
		m_j0 = a;
		m_j1 = b;
		push_row(OP_NONE, '0, '0, '0, 1'b0, 2'd1);
	endtask

	task automatic add_write(input logic [`CTRL_APB_AW-1:0] addr, input logic [31:0] data);
		logic err;
		err = (addr != regmap_pkg::REG_CONFIG);
		if (!err) begin
			m_cfg = data[regmap_pkg::CFG_BITS-1:0];
		end
		push_row(OP_WR, addr, data, '0, err, 2'd1);
	endtask

	task automatic add_read(input logic [`CTRL_APB_AW-1:0] addr);
		logic [31:0] d;
		logic        err;
		err = 1'b0;
		case (addr)
			regmap_pkg::REG_CONFIG:   d = 32'(m_cfg);
			regmap_pkg::REG_CONTROLS:
				d = 32'(expected_controls(m_keys, m_j0, m_j1, m_cfg[regmap_pkg::CFG_ROTATE]));
			regmap_pkg::REG_KEYS:     d = 32'(m_keys);
			regmap_pkg::REG_ID:       d = regmap_pkg::CORE_ID;
			default: begin
				d   = '0;
				err = 1'b1;
			end
		endcase
		push_row(OP_RD, addr, '0, d, err, 2'd0);
	endtask

	task automatic build_table();
		push_row(OP_NONE, '0, '0, '0, 1'b0, 2'd1); // reset state
		add_read(regmap_pkg::REG_CONFIG);
		add_read(regmap_pkg::REG_ID);
		for (int k = 0; k < 10; k++) begin
			add_key(CODE_POOL[k[3:0]], 1'b1);
			add_read(regmap_pkg::REG_KEYS);
			add_key(CODE_POOL[k[3:0]], 1'b0);
		end
		add_key(input_pkg::SC_UP, 1'b1);
		add_repeat(input_pkg::SC_UP, 1'b0);
		add_key(input_pkg::SC_UP, 1'b0);
		add_key(8'h1C, 1'b1);
		for (int b = 0; b < 6; b++) begin
			add_joy(8'h01 << b, 8'h00);
			add_joy(8'h00, 8'h01 << b);
		end
		add_key(input_pkg::SC_SPACE, 1'b1);
		add_joy(8'h08, 8'h20);
		add_key(input_pkg::SC_SPACE, 1'b0);
		add_joy(8'h00, 8'h00);
		add_write(regmap_pkg::REG_CONFIG, 32'h0000_0001); // rotation on
		for (int k = 0; k < 4; k++) begin
			add_key(CODE_POOL[k[3:0]], 1'b1);
			add_key(CODE_POOL[k[3:0]], 1'b0);
		end
		for (int b = 0; b < 4; b++) begin
			add_joy(8'h01 << b, 8'h00);
			add_joy(8'h00, 8'h01 << b);
		end
		add_joy(8'h00, 8'h00);
		add_write(regmap_pkg::REG_CONFIG, 32'h0000_000E);
		add_read(regmap_pkg::REG_CONFIG);
		add_key(input_pkg::SC_LEFT, 1'b1);
		add_key(input_pkg::SC_F2, 1'b1);
		add_joy(8'h10, 8'h00);
		add_read(regmap_pkg::REG_KEYS);
		add_read(regmap_pkg::REG_CONTROLS);
		add_write(regmap_pkg::REG_ID, 32'h0000_000F);
		add_read(4'h2);
		add_write(4'h6, 32'h0000_0001);
		add_read(regmap_pkg::REG_CONFIG);
		for (int n = 0; n < NUM_RANDOM; n++) begin
			rng = xorshift(rng);
			case (rng[1:0])
				2'd0, 2'd1: add_key(CODE_POOL[rng[11:8] % 4'd12], rng[2]);
				2'd2:       add_joy(rng[23:16], rng[31:24]);
				default:    add_write(regmap_pkg::REG_CONFIG, {28'd0, rng[19:16]});
			endcase
		end
		add_read(regmap_pkg::REG_KEYS);
		add_read(regmap_pkg::REG_CONTROLS);
	endtask

	task automatic final_report();
		$display("errors: %0d value, %0d timeout", value_errs, timeout_errs);
		if (value_errs == 0 && timeout_errs == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	endtask

	task automatic check_controls(input logic [input_pkg::CT_WIDTH-1:0] expected,
		input string what);
		if (controls !== expected) begin
			value_errs++;
			$display("CHECK FAILED at %0t: %s controls %03h, expected %03h",
				$time, what, controls, expected);
		end
	endtask

	task automatic check_apb_read(input logic [31:0] exp_data, input logic exp_err,
		input logic [31:0] got_data, input logic got_err, input logic with_data,
		input string what);
		if (got_err !== exp_err || (with_data && got_data !== exp_data)) begin
			value_errs++;
			$display("CHECK FAILED at %0t: %s apb data %08h err %b, expected %08h err %b",
				$time, what, got_data, got_err, exp_data, exp_err);
		end
	endtask

	task automatic check_config(input logic [1:0] exp_scan, input logic exp_rst,
		input string what);
		if (scanlines !== exp_scan || game_reset !== exp_rst) begin
			value_errs++;
			$display("CHECK FAILED at %0t: %s scanlines %0d game_reset %b, expected %0d %b",
				$time, what, scanlines, game_reset, exp_scan, exp_rst);
		end
	endtask

	task automatic wait_falling(input int n);
		for (int c = 0; c < n; c++) begin
			@(negedge clock_24);
		end
	endtask

	task automatic apb_transfer(input logic wr, input logic [`CTRL_APB_AW-1:0] addr,
		input logic [31:0] data, output logic [31:0] rdata, output logic err);
		int cnt;
		paddr   = addr;
		pwrite  = wr;
		pwdata  = data;
		psel    = 1'b1;
		penable = 1'b0;
		@(negedge clock_24);
		penable = 1'b1;
		#1;
		cnt = 0;
		while (!pready && cnt < TIMEOUT) begin
			@(negedge clock_24);
			#1;
			cnt++;
		end
		if (pready) begin
			rdata = prdata;
			err   = pslverr;
		end else begin
			$display("APB transfer to offset %0h timed out waiting for pready", addr);
			timeout_errs++;
			rdata = 'x;
			err   = 1'bx;
		end
		@(negedge clock_24);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apply_row(input int i);
		row_t        r;
		logic [31:0] rdata;
		logic        err;
		string       what;
		r    = rows[i];
		what = $sformatf("row %0d", i);
		@(negedge clock_24);
		ps2_key    = r.key;
		joystick_0 = r.j0;
		joystick_1 = r.j1;
		if (r.op != OP_NONE) begin
			apb_transfer(r.op == OP_WR, r.addr, r.wdata, rdata, err);
			check_apb_read(r.exp_data, r.exp_err, rdata, err, r.op == OP_RD, what);
			#1;
			check_config(r.exp_scan, r.exp_rst, what); // right after the access edge
		end
		wait_falling(int'(r.lat));
		#1; // away from the rising edge
		check_controls(r.exp_ctrl, what);
		check_config(r.exp_scan, r.exp_rst, what);
	endtask

	initial begin
		rst_n        = 1'b0;
		ps2_key      = '0;
		joystick_0   = '0;
		joystick_1   = '0;
		paddr        = '0;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		pwdata       = '0;
		value_errs   = 0;
		timeout_errs = 0;
		rng          = 32'h37f6;
		m_toggle     = 1'b0;
		m_keys       = '0;
		m_cfg        = '0;
		m_ps2        = '0;
		m_j0         = '0;
		m_j1         = '0;
		build_table();
		for (int c = 0; c < 10; c++) begin
			@(posedge clock_24);
		end
		@(negedge clock_24);
		rst_n = 1'b1;
		for (int i = 0; i < rows.size(); i++) begin
			apply_row(i);
		end
		final_report();
	end

endmodule

// File: list.f
+incdir+.
input_pkg.sv
regmap_pkg.sv
ps2_key_decoder.sv
ctrl_apb_regs.sv
control_mapper.sv
arcade_input_top.sv
arcade_input_chk.sv
tb_arcade_input.sv

// File: Makefile
VERILATOR  ?= verilator
FILELIST   ?= list.f
TB_TOP     ?= tb_arcade_input
RTL_TOP    ?= arcade_input_top
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert

FAIL_MSG := Regression failed
PASS_MSG := Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported errors"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
